/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module dc_block_tb -Mdir obj_dir
	./obj_dir/Vdc_block_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without passing"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* sim/dc_block_assertions.sv */
`timescale 1ns/100ps

module dc_block_assertions
  import sample_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    in_rdy,
  input sample_t out_sample,
  input logic    out_val,
  input logic    out_rdy
);

  // A stalled output sample must not change
  out_sample_held: assert property (
    @(posedge clk) disable iff (reset)
    out_val && !out_rdy |=> $stable(out_sample)
  ) else $error("out_sample changed while out_val was high and out_rdy low");

  // Input side is open as soon as reset has been applied
  in_rdy_after_reset: assert property (
    @(posedge clk)
    reset |=> in_rdy
  ) else $error("in_rdy was low after a reset cycle");

  out_val_low_in_reset: assert property (
    @(posedge clk)
    reset |=> !out_val
  ) else $error("out_val was high after a reset cycle");

endmodule

/* sim/dc_block_tb.sv */
`timescale 1ns/100ps

module dc_block_tb
  import sample_pkg::*;
  import block_pkg::*;
();

  localparam int RESET_CYCLES   = 16;
  localparam int TOTAL_BLOCKS   = 18;
  localparam int STALL_FACTOR   = 8;
  localparam int TIMEOUT_CYCLES =
    RESET_CYCLES + TOTAL_BLOCKS * N_SAMPLES * STALL_FACTOR + 200;
  localparam int LATENCY        = 3;
  localparam int DRAIN_CYCLES   = 12;

  logic    clk;
  logic    reset;
  sample_t in_sample;
  logic    in_val;
  logic    in_rdy;
  sample_t out_sample;
  logic    out_val;
  logic    out_rdy;

  logic [31:0] lfsr_state;
  int          cycle = 0;
  bit          gap_mode;
  bit          stall_mode;
  bit          in_taken;
  int          rdy_low_cycles;

  sample_t send_q[$];
  sample_t expect_q[$];
  sample_t got_q[$];
  int      accept_edges[$];
  int      xfer_edges[$];

  dc_block_top dc_block_top_i (
    .clk        (clk),
    .reset      (reset),
    .in_sample  (in_sample),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .out_sample (out_sample),
    .out_val    (out_val),
    .out_rdy    (out_rdy)
  );

  bind dc_block_top dc_block_assertions dc_block_assertions_i (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout");
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic feedback;
    feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], feedback};
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Queues the inputs and the expected outputs of one block
  task automatic queue_block(input sample_t blk [N_SAMPLES]);
    int sum;
    int mean;
    sum = 0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      sum += int'(blk[i]);
    end
    // Shift of a negative sum rounds toward minus infinity
    mean = sum >>> 3;
    for (int i = 0; i < N_SAMPLES; i++) begin
      send_q.push_back(blk[i]);
      expect_q.push_back(sample_t'(int'(blk[i]) - mean));
    end
  endtask

  task automatic queue_random_block();
    sample_t blk [N_SAMPLES];
    for (int i = 0; i < N_SAMPLES; i++) begin
      blk[i] = sample_t'(random_bits(16));
    end
    queue_block(blk);
  endtask

  // One clock cycle of stimulus and observation at the falling edge
  task automatic advance_cycle();
    @(negedge clk);
    if (in_taken) begin
      void'(send_q.pop_front());
    end
    if (!in_val || in_taken) begin
      if (send_q.size() > 0 && !(gap_mode && random_bits(1) == 32'd0)) begin
        in_val    = 1'b1;
        in_sample = send_q[0];
      end else begin
        in_val = 1'b0;
      end
    end
    out_rdy = stall_mode ? (random_bits(1) != 32'd0) : 1'b1;
    // Handshakes that complete at the coming rising edge
    in_taken = in_val && in_rdy;
    if (in_taken) begin
      accept_edges.push_back(cycle + 1);
    end
    if (!in_rdy) begin
      rdy_low_cycles++;
    end
    if (out_val && out_rdy) begin
      got_q.push_back(out_sample);
      xfer_edges.push_back(cycle + 1);
    end
  endtask

  task automatic clear_records();
    send_q.delete();
    expect_q.delete();
    got_q.delete();
    accept_edges.delete();
    xfer_edges.delete();
    rdy_low_cycles = 0;
  endtask

  task automatic finish_test(string name);
    int n;
    n = expect_q.size();
    while (got_q.size() < n) begin
      advance_cycle();
    end
    // Anything arriving late would be a duplicate
    repeat (DRAIN_CYCLES) advance_cycle();
    check_value({name, " output count"}, 32'(n), 32'(got_q.size()));
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("out_sample[%0d] in %s", i, name),
                  32'(expect_q[i]), 32'(got_q[i]));
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_value("out_val", 32'd0, 32'(out_val));
    check_value("in_rdy", 32'd1, 32'(in_rdy));
  endtask

  task automatic test_constant_and_random();
    sample_t blk [N_SAMPLES];
    clear_records();
    blk = '{default: 16'sh1234};
    queue_block(blk);
    queue_random_block();
    finish_test("constant and random");
  endtask

  task automatic test_sign_and_wrap();
    sample_t blk [N_SAMPLES];
    clear_records();
    blk = '{default: 16'sh0000};
    blk[0] = -16'sd1;
    queue_block(blk);
    blk = '{-16'sd5, 16'sd3, -16'sd7, 16'sd2, -16'sd9, 16'sd1, -16'sd4, 16'sd6};
    queue_block(blk);
    blk = '{default: 16'sh7fff};
    for (int i = 4; i < N_SAMPLES; i++) begin
      blk[i] = 16'sh8000;
    end
    queue_block(blk);
    blk = '{default: 16'sh8000};
    blk[0] = 16'sh7fff;
    queue_block(blk);
    finish_test("sign and wrap");
  endtask

  task automatic test_back_to_back();
    clear_records();
    repeat (4) queue_random_block();
    finish_test("back to back");
    for (int b = 0; b < 4; b++) begin
      check_value($sformatf("out_val latency of block %0d", b), 32'(LATENCY),
                  32'(xfer_edges[b * N_SAMPLES] - accept_edges[b * N_SAMPLES + 7]));
    end
  endtask

  task automatic test_output_backpressure();
    clear_records();
    stall_mode = 1'b1;
    repeat (4) queue_random_block();
    finish_test("output back-pressure");
    stall_mode = 1'b0;
    check_value("in_rdy low seen", 32'd1, 32'(rdy_low_cycles > 0));
  endtask

  task automatic test_gapped_input();
    clear_records();
    gap_mode = 1'b1;
    repeat (4) queue_random_block();
    finish_test("gapped input");
    gap_mode = 1'b0;
  endtask

  initial begin
    reset      = 1'b1;
    in_val     = 1'b0;
    in_sample  = '0;
    out_rdy    = 1'b0;
    lfsr_state = 32'h2315;
    gap_mode   = 1'b0;
    stall_mode = 1'b0;
    in_taken   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_reset_state();
    test_constant_and_random();
    test_sign_and_wrap();
    test_back_to_back();
    test_output_backpressure();
    test_gapped_input();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
verilog/sample_pkg.sv
verilog/block_pkg.sv
verilog/block_deserializer.sv
verilog/dc_remover.sv
verilog/block_serializer.sv
verilog/dc_block_top.sv
sim/dc_block_assertions.sv
sim/dc_block_tb.sv

/* verilog/block_deserializer.sv */
`timescale 1ns/100ps

module block_deserializer
  import sample_pkg::*;
  import block_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  sample_t in_sample,
  input  logic    in_val,
  output logic    in_rdy,

  output block_t  des_block,
  output logic    des_val,
  input  logic    des_rdy
);

  index_t index;
  logic   full;
  logic   accept;
  logic   take;
  logic   last_slot;
  block_t block_q;

  // No new samples while a complete block waits downstream
  assign in_rdy = !full;

  assign accept    = in_val && in_rdy;
  assign take      = des_val && des_rdy;
  assign last_slot = (index == LAST_INDEX);

  assign des_block = block_q;
  assign des_val   = full;

  // Slot write pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (accept) begin
      index <= index + 1'b1;
    end
  end

  // Set when the last slot is written, cleared by the downstream transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (accept && last_slot) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  // Sample storage
  always_ff @(posedge clk) begin
    if (accept) begin
      block_q.samples[index] <= in_sample;
    end
  end

endmodule

/* verilog/block_pkg.sv */
package block_pkg;

  import sample_pkg::*;

  // Block geometry
  localparam int N_SAMPLES = 8;
  localparam int LOG2_N = $clog2(N_SAMPLES);

  // Position of a sample inside a block
  typedef logic [LOG2_N-1:0] index_t;

  // Slot of the last sample in a block
  localparam index_t LAST_INDEX = index_t'(N_SAMPLES - 1);

  // Element 0 holds the first sample received
  typedef struct packed {
    sample_t [N_SAMPLES-1:0] samples;
  } block_t;

endpackage

/* verilog/block_serializer.sv */
`timescale 1ns/100ps

module block_serializer
  import sample_pkg::*;
  import block_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  block_t  dc_block,
  input  logic    dc_val,
  output logic    dc_rdy,

  output sample_t out_sample,
  output logic    out_val,
  input  logic    out_rdy
);

  typedef enum logic {
    LOAD,
    SEND
  } state_t;

  state_t state;
  state_t state_next;
  index_t index;
  index_t index_next;
  logic   load_en;
  logic   send_xfer;
  block_t block_q;

  // Outputs follow the state only, never the handshake inputs
  always_comb begin
    case (state)
      LOAD: begin
        dc_rdy  = 1'b1;
        out_val = 1'b0;
      end
      SEND: begin
        dc_rdy  = 1'b0;
        out_val = 1'b1;
      end
      default: begin
        dc_rdy  = 1'b1;
        out_val = 1'b0;
      end
    endcase
  end

  assign load_en   = dc_val && dc_rdy;
  assign send_xfer = out_val && out_rdy;

  always_comb begin
    state_next = state;
    index_next = index;
    case (state)
      LOAD: begin
        index_next = '0;
        if (dc_val) begin
          state_next = SEND;
        end
      end
      SEND: begin
        // Index holds while the receiver stalls
        if (send_xfer) begin
          if (index == LAST_INDEX) begin
            state_next = LOAD;
            index_next = '0;
          end else begin
            index_next = index + 1'b1;
          end
        end
      end
      default: begin
        state_next = LOAD;
        index_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= LOAD;
      index <= '0;
    end else begin
      state <= state_next;
      index <= index_next;
    end
  end

  // Block capture, only in the load state
  always_ff @(posedge clk) begin
    if (load_en) begin
      block_q <= dc_block;
    end
  end

  assign out_sample = block_q.samples[index];

endmodule

/* verilog/dc_block_top.sv */
`timescale 1ns/100ps

module dc_block_top
  import sample_pkg::*;
  import block_pkg::*;
(
  input  logic    clk,
  input  logic    reset,

  input  sample_t in_sample,
  input  logic    in_val,
  output logic    in_rdy,

  output sample_t out_sample,
  output logic    out_val,
  input  logic    out_rdy
);

  // Deserializer to DC remover
  block_t des_block;
  logic   des_val;
  logic   des_rdy;

  // DC remover to serializer
  block_t dc_block;
  logic   dc_val;
  logic   dc_rdy;

  block_deserializer block_deserializer_i (
    .clk       (clk),
    .reset     (reset),
    .in_sample (in_sample),
    .in_val    (in_val),
    .in_rdy    (in_rdy),
    .des_block (des_block),
    .des_val   (des_val),
    .des_rdy   (des_rdy)
  );

  dc_remover dc_remover_i (
    .clk       (clk),
    .reset     (reset),
    .des_block (des_block),
    .des_val   (des_val),
    .des_rdy   (des_rdy),
    .dc_block  (dc_block),
    .dc_val    (dc_val),
    .dc_rdy    (dc_rdy)
  );

  block_serializer block_serializer_i (
    .clk        (clk),
    .reset      (reset),
    .dc_block   (dc_block),
    .dc_val     (dc_val),
    .dc_rdy     (dc_rdy),
    .out_sample (out_sample),
    .out_val    (out_val),
    .out_rdy    (out_rdy)
  );

endmodule

/* verilog/dc_remover.sv */
`timescale 1ns/100ps

module dc_remover
  import sample_pkg::*;
  import block_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  input  block_t des_block,
  input  logic   des_val,
  output logic   des_rdy,

  output block_t dc_block,
  output logic   dc_val,
  input  logic   dc_rdy
);

  logic   valid_q;
  logic   accept;
  sum_t   block_sum;
  sum_t   mean;
  sample_t mean_sample;
  block_t corrected;
  block_t block_q;

  // Single slot: free when empty or when the held block leaves this cycle
  assign des_rdy = !valid_q || dc_rdy;
  assign accept  = des_val && des_rdy;

  assign dc_block = block_q;
  assign dc_val   = valid_q;

  // Sum of the incoming block
  always_comb begin
    block_sum = '0;
    for (int i = 0; i < N_SAMPLES; i++) begin
      block_sum = block_sum + widen(des_block.samples[i]);
    end
  end

  // Arithmetic shift gives floor division, so -1 / 8 rounds to -1
  assign mean        = block_sum >>> LOG2_N;
  assign mean_sample = wrap(mean);

  // Subtract the mean from every sample, results wrap at 16 bits
  always_comb begin
    for (int i = 0; i < N_SAMPLES; i++) begin
      corrected.samples[i] = des_block.samples[i] - mean_sample;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (dc_rdy) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      block_q <= corrected;
    end
  end

endmodule

/* verilog/sample_pkg.sv */
package sample_pkg;

  // One input or output sample
  localparam int SAMPLE_WIDTH = 16;

  // Eight samples add at most three bits of growth
  localparam int SUM_WIDTH = SAMPLE_WIDTH + 3;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // Sign extend a sample to the width of a block sum
  function automatic sum_t widen(sample_t s);
    return sum_t'(s);
  endfunction

  // Drop the growth bits, two's complement wrap
  function automatic sample_t wrap(sum_t s);
    return sample_t'(s[SAMPLE_WIDTH-1:0]);
  endfunction

endpackage
